//--- source/i2c_target_pkg.sv
// i2c write-only target shared definitions
// widths, filter depth, fsm state encoding and the two packed structs

package i2c_target_pkg;

    // 7-bit addressing only
    localparam int ADDR_W = 7;

    // data byte on the bus and on the stream
    localparam int BYTE_W = 8;

    // samples that must agree before a clean level moves
    localparam int FILTER_LEN = 4;

    // counts down 7..0 for address and data bits
    localparam int BIT_COUNT_W = 3;

    typedef enum logic [2:0] {
        STATE_IDLE,
        STATE_ADDRESS,
        STATE_ACK,
        // ack done, waiting on the output slot
        STATE_WRITE_WAIT,
        STATE_WRITE_BITS
    } target_state_t;

    // filtered bus view, pulses are one cycle wide
    typedef struct packed {
        logic scl_level;
        logic sda_level;
        logic scl_rise;
        logic scl_fall;
        // sda falls while scl high
        logic start;
        // sda rises while scl high
        logic stop;
    } bus_event_t;

    // one stream beat
    typedef struct packed {
        logic [BYTE_W-1:0] data;
        // final byte of a write transfer
        logic              last;
    } stream_byte_t;

endpackage

//--- source/i2c_line_conditioner.sv
// i2c line conditioner
// glitch filter on scl and sda, then edge, start and stop detection

`timescale 1ns/1ns

module i2c_line_conditioner import i2c_target_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       scl_line,
    input  logic       sda_line,
    output bus_event_t bus_event
);

    // bit 0 is scl, bit 1 is sda
    logic [1:0]                 lines;
    logic [1:0][FILTER_LEN-1:0] hist;
    logic [1:0]                 clean;
    logic [1:0]                 prev;

    logic scl_rise_q;
    logic scl_fall_q;
    logic start_q;
    logic stop_q;

    assign lines = {sda_line, scl_line};

    always_ff @(posedge clk) begin
        if (rst) begin
            // idle bus is high on both lines
            hist       <= '1;
            clean      <= '1;
            prev       <= '1;
            scl_rise_q <= 1'b0;
            scl_fall_q <= 1'b0;
            start_q    <= 1'b0;
            stop_q     <= 1'b0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                hist[i] <= {hist[i][FILTER_LEN-2:0], lines[i]};
                // move only when the whole history agrees
                if (hist[i] == '1) begin
                    clean[i] <= 1'b1;
                end else if (hist[i] == '0) begin
                    clean[i] <= 1'b0;
                end
            end
            prev <= clean;
            // pulses land one cycle after the clean level moves
            scl_rise_q <= clean[0] & ~prev[0];
            scl_fall_q <= ~clean[0] & prev[0];
            // sda edge with scl high is a bus condition, not data
            start_q    <= ~clean[1] & prev[1] & clean[0];
            stop_q     <= clean[1] & ~prev[1] & clean[0];
        end
    end

    assign bus_event = '{
        scl_level: clean[0],
        sda_level: clean[1],
        scl_rise:  scl_rise_q,
        scl_fall:  scl_fall_q,
        start:     start_q,
        stop:      stop_q
    };

endmodule

//--- source/i2c_target_fsm.sv
// i2c target fsm for write transfers
// address match, ack drive, bit shifting and scl stretch on a busy slot

`timescale 1ns/1ns

module i2c_target_fsm import i2c_target_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  bus_event_t        bus_event,
    input  logic              enable,
    input  logic [ADDR_W-1:0] device_address,
    input  logic              slot_free,
    output logic              scl_release,
    output logic              sda_release,
    output logic              bus_addressed,
    output logic              byte_done,
    output logic [BYTE_W-1:0] byte_data,
    output logic              slot_claim
);

    target_state_t          state;
    logic [BIT_COUNT_W-1:0] bit_cnt;
    logic [BYTE_W-1:0]      shift_q;
    logic                   addr_match;

    // after seven shifts the address sits in the low bits
    assign addr_match = (shift_q[ADDR_W-1:0] == device_address);

    // shift register holds the full byte in the byte_done cycle
    assign byte_data = shift_q;

    always_ff @(posedge clk) begin
        // single-cycle strobes
        byte_done  <= 1'b0;
        slot_claim <= 1'b0;

        if (rst) begin
            state         <= STATE_IDLE;
            bit_cnt       <= '0;
            scl_release   <= 1'b1;
            sda_release   <= 1'b1;
            bus_addressed <= 1'b0;
        end else if (bus_event.start) begin
            // start or repeated start, fresh address phase
            state         <= STATE_ADDRESS;
            bit_cnt       <= BIT_COUNT_W'(ADDR_W);
            scl_release   <= 1'b1;
            sda_release   <= 1'b1;
            bus_addressed <= 1'b0;
        end else if (bus_event.stop) begin
            state         <= STATE_IDLE;
            scl_release   <= 1'b1;
            sda_release   <= 1'b1;
            bus_addressed <= 1'b0;
        end else begin
            case (state)
                STATE_ADDRESS: begin
                    if (bus_event.scl_rise) begin
                        if (bit_cnt != '0) begin
                            // address bits, msb first
                            shift_q <= {shift_q[BYTE_W-2:0], bus_event.sda_level};
                            bit_cnt <= bit_cnt - 1'b1;
                        end else if (addr_match && enable && !bus_event.sda_level) begin
                            // r/w low means write
                            bus_addressed <= 1'b1;
                            state         <= STATE_ACK;
                        end else begin
                            // other device, disabled or read request
                            state <= STATE_IDLE;
                        end
                    end
                end

                STATE_ACK: begin
                    // sda_release doubles as the ack phase marker
                    if (bus_event.scl_fall) begin
                        if (sda_release) begin
                            // first fall after the 8th bit, pull sda low
                            sda_release <= 1'b0;
                        end else begin
                            // ack clock over
                            sda_release <= 1'b1;
                            state       <= STATE_WRITE_WAIT;
                        end
                    end
                end

                STATE_WRITE_WAIT: begin
                    if (slot_free) begin
                        // room downstream, let the clock run
                        scl_release <= 1'b1;
                        slot_claim  <= 1'b1;
                        bit_cnt     <= BIT_COUNT_W'(BYTE_W - 1);
                        state       <= STATE_WRITE_BITS;
                    end else if (!bus_event.scl_level) begin
                        // stretch, only grab scl while it is already low
                        scl_release <= 1'b0;
                    end
                end

                STATE_WRITE_BITS: begin
                    if (bus_event.scl_rise) begin
                        shift_q <= {shift_q[BYTE_W-2:0], bus_event.sda_level};
                        if (bit_cnt == '0) begin
                            // 8th bit in, hand off and ack
                            byte_done <= 1'b1;
                            state     <= STATE_ACK;
                        end else begin
                            bit_cnt <= bit_cnt - 1'b1;
                        end
                    end
                end

                default: begin
                    // idle, only a start gets us out
                    state <= STATE_IDLE;
                end
            endcase
        end
    end

endmodule

//--- source/i2c_write_buffer.sv
// i2c write buffer
// holds each byte back one byte time so the final byte can carry last

`timescale 1ns/1ns

module i2c_write_buffer import i2c_target_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  bus_event_t        bus_event,
    input  logic              byte_done,
    input  logic [BYTE_W-1:0] byte_data,
    input  logic              slot_claim,
    input  logic              out_ready,
    output logic              slot_free,
    output stream_byte_t      out_byte,
    output logic              out_valid
);

    // most recent byte, not yet in the output register
    logic              pending;
    logic [BYTE_W-1:0] pending_data;
    // output register loaded but not yet presented
    logic              staged;

    logic end_event;
    logic claim_move;
    logic flush_pending;

    // start or stop closes the current transfer
    assign end_event = bus_event.start | bus_event.stop;

    assign claim_move = slot_claim & pending;

    // transfer ended before the pending byte reached the output register
    assign flush_pending = end_event & pending & ~staged;

    // fsm stretches scl while this is low
    assign slot_free = ~out_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending   <= 1'b0;
            staged    <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
            if (end_event) begin
                if (staged || pending) begin
                    out_valid <= 1'b1;
                end
                staged  <= 1'b0;
                pending <= 1'b0;
            end else if (byte_done) begin
                // a newer byte exists, so the staged one is not last
                if (staged) begin
                    out_valid <= 1'b1;
                end
                staged  <= 1'b0;
                pending <= 1'b1;
            end else if (claim_move) begin
                staged  <= 1'b1;
                pending <= 1'b0;
            end
        end
    end

    // payload path
    always_ff @(posedge clk) begin
        if (byte_done) begin
            pending_data <= byte_data;
        end
        if (claim_move || flush_pending) begin
            out_byte.data <= pending_data;
        end
        if (end_event && (staged || pending)) begin
            out_byte.last <= 1'b1;
        end else if (claim_move) begin
            out_byte.last <= 1'b0;
        end
    end

endmodule

//--- source/i2c_target_top.sv
// i2c write-only target top level
// line conditioner, target fsm and write buffer in a chain

`timescale 1ns/1ns

module i2c_target_top import i2c_target_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              scl_line,
    input  logic              sda_line,
    input  logic              enable,
    input  logic [ADDR_W-1:0] device_address,
    input  logic              out_ready,
    output logic              scl_release,
    output logic              sda_release,
    output logic              bus_addressed,
    output stream_byte_t      out_byte,
    output logic              out_valid
);

    bus_event_t        bus_event;
    logic              byte_done;
    logic [BYTE_W-1:0] byte_data;
    logic              slot_claim;
    logic              slot_free;

    // filtered levels and bus condition pulses
    i2c_line_conditioner u_conditioner (
        .clk       (clk),
        .rst       (rst),
        .scl_line  (scl_line),
        .sda_line  (sda_line),
        .bus_event (bus_event)
    );

    i2c_target_fsm u_fsm (
        .clk            (clk),
        .rst            (rst),
        .bus_event      (bus_event),
        .enable         (enable),
        .device_address (device_address),
        .slot_free      (slot_free),
        .scl_release    (scl_release),
        .sda_release    (sda_release),
        .bus_addressed  (bus_addressed),
        .byte_done      (byte_done),
        .byte_data      (byte_data),
        .slot_claim     (slot_claim)
    );

    // one byte of hold-back before the stream
    i2c_write_buffer u_buffer (
        .clk        (clk),
        .rst        (rst),
        .bus_event  (bus_event),
        .byte_done  (byte_done),
        .byte_data  (byte_data),
        .slot_claim (slot_claim),
        .out_ready  (out_ready),
        .slot_free  (slot_free),
        .out_byte   (out_byte),
        .out_valid  (out_valid)
    );

endmodule

//--- sim/i2c_target_assertions.sv
// protocol checks for the i2c write target
// reset values, stream hold under back-pressure, ack only while addressed

`timescale 1ns/1ns

module i2c_target_assertions import i2c_target_pkg::*; (
    input logic         clk,
    input logic         rst,
    input logic         out_ready,
    input logic         out_valid,
    input stream_byte_t out_byte,
    input logic         scl_release,
    input logic         sda_release,
    input logic         bus_addressed
);

    // lines free, stream empty, not addressed
    reset_values: assert property (@(posedge clk)
        rst |=> (scl_release && sda_release && !out_valid && !bus_addressed))
        else $error("outputs not at their reset values after reset");

    // a presented byte waits for the consumer
    stream_hold: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_byte)))
        else $error("out_valid or out_byte changed while out_ready was low");

    // sda is only pulled for an ack to our own address
    ack_when_addressed: assert property (@(posedge clk) disable iff (rst)
        !sda_release |-> bus_addressed)
        else $error("sda pulled low while the target was not addressed");

endmodule

//--- sim/tb_i2c_target.sv
// testbench for the i2c write-only target
// bit-banged controller on a wired-and bus, stream monitor and per-test results

`timescale 1ns/1ns

module tb_i2c_target import i2c_target_pkg::*; ();

    logic              clk = 1'b0;
    logic              rst;
    logic              scl_drv;
    logic              sda_drv;
    logic              enable;
    logic [ADDR_W-1:0] device_address;
    logic              out_ready;
    logic              scl_release;
    logic              sda_release;
    logic              bus_addressed;
    logic              out_valid;
    stream_byte_t      out_byte;
    logic              scl_line;
    logic              sda_line;

    stream_byte_t got_q[$];
    stream_byte_t exp_q[$];
    int           seed = 61;
    int           errors = 0;
    int           errors_before = 0;
    int           tests_run = 0;
    int           tests_failed = 0;
    logic         stretch_seen;
    logic         addressed_seen;

    always #5 clk = ~clk;

    // open drain, either side pulls low
    assign scl_line = scl_drv & scl_release;
    assign sda_line = sda_drv & sda_release;

    i2c_target_top uut (
        .clk            (clk),
        .rst            (rst),
        .scl_line       (scl_line),
        .sda_line       (sda_line),
        .enable         (enable),
        .device_address (device_address),
        .out_ready      (out_ready),
        .scl_release    (scl_release),
        .sda_release    (sda_release),
        .bus_addressed  (bus_addressed),
        .out_byte       (out_byte),
        .out_valid      (out_valid)
    );

    bind i2c_target_top i2c_target_assertions protocol_checks (
        .clk           (clk),
        .rst           (rst),
        .out_ready     (out_ready),
        .out_valid     (out_valid),
        .out_byte      (out_byte),
        .scl_release   (scl_release),
        .sda_release   (sda_release),
        .bus_addressed (bus_addressed)
    );

    // stream monitor, pre-edge values at the transfer edge
    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            got_q.push_back(out_byte);
        end
        if (bus_addressed) begin
            addressed_seen = 1'b1;
        end
    end

    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    // the target may hold scl low, flag anything past a couple of cycles
    task automatic wait_scl_high();
        int n;
        n = 0;
        while (scl_line !== 1'b1 && n < 4000) begin
            @(negedge clk);
            n++;
            if (n > 2) stretch_seen = 1'b1;
        end
        if (n >= 4000) abort_run("scl never released by the target");
    endtask

    // from idle, or repeated start with scl low
    task automatic send_start();
        if (!scl_drv) begin
            wait_cycles(10);
            sda_drv = 1'b1;
            wait_cycles(10);
            scl_drv = 1'b1;
            wait_scl_high();
            wait_cycles(10);
        end
        sda_drv = 1'b0;
        wait_cycles(10);
        scl_drv = 1'b0;
    endtask

    task automatic send_stop();
        wait_cycles(10);
        sda_drv = 1'b0;
        wait_cycles(10);
        scl_drv = 1'b1;
        wait_scl_high();
        wait_cycles(10);
        sda_drv = 1'b1;
        wait_cycles(20);
    endtask

    // 40 cycle scl period, sda moves mid low phase, sampled mid high phase
    task automatic clock_bit(input logic b, output logic seen);
        wait_cycles(10);
        sda_drv = b;
        wait_cycles(10);
        scl_drv = 1'b1;
        wait_scl_high();
        wait_cycles(10);
        seen = sda_line;
        wait_cycles(10);
        scl_drv = 1'b0;
    endtask

    // msb first, ninth clock reads the ack
    task automatic send_byte(input logic [7:0] b, output logic ack);
        logic seen;
        for (int i = 7; i >= 0; i--) begin
            clock_bit(b[i], seen);
        end
        clock_bit(1'b1, seen);
        ack = ~seen;
    endtask

    task automatic address_phase(input logic [ADDR_W-1:0] addr, input logic expect_ack);
        logic ack;
        send_byte({addr, 1'b0}, ack);
        check_value("address ack", 32'(ack), 32'(expect_ack));
    endtask

    // random bytes, the final one of the transfer carries last
    task automatic data_phase(input int count);
        logic         ack;
        logic [7:0]   b;
        stream_byte_t e;
        for (int i = 0; i < count; i++) begin
            b = 8'($random(seed));
            send_byte(b, ack);
            check_value("data ack", 32'(ack), 32'(1'b1));
            e.data = b;
            e.last = (i == count - 1);
            exp_q.push_back(e);
        end
    endtask

    task automatic open_after_stretch();
        int k;
        k = 0;
        while (!stretch_seen && k < 20000) begin
            @(negedge clk);
            k++;
        end
        wait_cycles(100);
        out_ready = 1'b1;
    endtask

    task automatic check_stream(input int n);
        int           k;
        stream_byte_t g;
        stream_byte_t e;
        k = 0;
        while (got_q.size() < n && k < 20000) begin
            @(negedge clk);
            k++;
        end
        if (got_q.size() < n) begin
            abort_run("stream bytes did not arrive before the timeout");
        end else begin
            wait_cycles(100);
            check_value("stream count", 32'(got_q.size()), 32'(exp_q.size()));
            while (got_q.size() > 0 && exp_q.size() > 0) begin
                g = got_q.pop_front();
                e = exp_q.pop_front();
                check_value("out_byte.data", 32'(g.data), 32'(e.data));
                check_value("out_byte.last", 32'(g.last), 32'(e.last));
            end
            got_q.delete();
            exp_q.delete();
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors > errors_before) begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
        errors_before = errors;
    endtask

    initial begin
        rst = 1'b1;
        scl_drv = 1'b1;
        sda_drv = 1'b1;
        enable = 1'b1;
        device_address = 7'h3a;
        out_ready = 1'b1;
        stretch_seen = 1'b0;
        addressed_seen = 1'b0;
        wait_cycles(8);
        rst = 1'b0;
        wait_cycles(10);

        check_value("reset outputs", 32'({scl_release, sda_release, out_valid, bus_addressed}),
                    32'(4'b1100));
        report_test("reset values");

        send_start();
        address_phase(device_address, 1'b1);
        data_phase(5);
        send_stop();
        check_stream(5);
        report_test("five byte write");

        // wrong address, then right address while disabled
        addressed_seen = 1'b0;
        send_start();
        address_phase(device_address ^ 7'h05, 1'b0);
        send_stop();
        enable = 1'b0;
        send_start();
        address_phase(device_address, 1'b0);
        send_stop();
        enable = 1'b1;
        wait_cycles(100);
        check_value("bus_addressed", 32'(addressed_seen), 32'(1'b0));
        check_value("stream count", 32'(got_q.size()), 32'(0));
        report_test("address nack");

        out_ready = 1'b0;
        stretch_seen = 1'b0;
        fork
            begin
                send_start();
                address_phase(device_address, 1'b1);
                data_phase(3);
                send_stop();
            end
            open_after_stretch();
        join
        check_value("scl stretch", 32'(stretch_seen), 32'(1'b1));
        check_stream(3);
        report_test("back-pressure stretch");

        // repeated start splits the stream into two transfers
        send_start();
        address_phase(device_address, 1'b1);
        data_phase(2);
        send_start();
        address_phase(device_address, 1'b1);
        data_phase(1);
        send_stop();
        check_stream(3);
        report_test("repeated start");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- all.f
source/i2c_target_pkg.sv
source/i2c_line_conditioner.sv
source/i2c_target_fsm.sv
source/i2c_write_buffer.sv
source/i2c_target_top.sv
sim/i2c_target_assertions.sv
sim/tb_i2c_target.sv

//--- run_sim.sh
#!/bin/sh
# build and run the i2c target testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_i2c_target \
    --Mdir obj_dir -o sim_i2c_target -f all.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_i2c_target > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: PASS" sim.log; then
    exit 0
fi
exit 1
